//--- source/icache_pkg.sv
package icache_pkg;

    // Byte address and instruction word widths.
    localparam int ADDR_W   = 16;
    localparam int WORD_W   = 32;

    // Byte offset inside one 32-bit word.
    localparam int OFFSET_W = 2;

    // Fetch request from the CPU.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    // Fetch response to the CPU.
    typedef struct packed {
        logic [WORD_W-1:0] data;
    } fetch_rsp_t;

    // Refill request towards memory, word aligned.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    // Bank controller states.
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE
    } bank_state_e;

endpackage

//--- source/fetch_dispatch.sv
module fetch_dispatch #(
    parameter int NUM_BANKS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   req_valid,
    input  icache_pkg::fetch_req_t req,
    output logic                   req_ready,
    input  logic [NUM_BANKS-1:0]   bank_busy,
    input  logic                   rsp_done,
    output logic [NUM_BANKS-1:0]   start,
    output icache_pkg::fetch_req_t bank_req
);
    import icache_pkg::*;

    localparam int SEL_W = $clog2(NUM_BANKS);

    logic             in_flight;
    logic             accept;
    logic [SEL_W-1:0] bank_sel;

    assign bank_sel = req.addr[OFFSET_W +: SEL_W];   // Bits just above byte offset.

    // Only one fetch in flight at a time.
    assign req_ready = !in_flight && !(|bank_busy) && !(|start) && !flush;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            in_flight <= 1'b0;
            start     <= '0;
        end
        else
        begin
            start <= accept ? (NUM_BANKS'(1) << bank_sel) : '0;   // One-cycle pulse.
            if (accept)
                in_flight <= 1'b1;
            else if (rsp_done)
                in_flight <= 1'b0;
        end
    end

    // Held until the next accepted fetch.
    always_ff @(posedge clk)
    begin
        if (accept)
            bank_req <= req;
    end

endmodule

//--- source/icache_bank.sv
module icache_bank #(
    parameter int NUM_BANKS     = 4,
    parameter int SETS_PER_BANK = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          start,
    input  icache_pkg::fetch_req_t        req,
    output logic                          busy,
    output logic                          rsp_valid,
    output icache_pkg::fetch_rsp_t        rsp,
    output logic                          mem_valid,
    output icache_pkg::mem_req_t          mem_req,
    input  logic                          mem_ready,
    input  logic [icache_pkg::WORD_W-1:0] mem_data
);
    import icache_pkg::*;

    localparam int SEL_W = $clog2(NUM_BANKS);
    localparam int IDX_W = $clog2(SETS_PER_BANK);
    localparam int TAG_W = ADDR_W - OFFSET_W - SEL_W - IDX_W;

    bank_state_e              state;
    bank_state_e              state_next;
    fetch_req_t               req_q;
    logic [SETS_PER_BANK-1:0] valid_q;
    logic [TAG_W-1:0]         tag_mem [SETS_PER_BANK];
    logic [WORD_W-1:0]        data_mem [SETS_PER_BANK];
    logic [IDX_W-1:0]         index;
    logic [TAG_W-1:0]         tag;
    logic                     hit;
    logic                     refill;

    // Address split: tag | index | bank select | byte offset.
    assign index = req_q.addr[OFFSET_W + SEL_W +: IDX_W];
    assign tag   = req_q.addr[ADDR_W-1 -: TAG_W];

    assign hit    = valid_q[index] && (tag_mem[index] == tag);
    assign refill = (state == ALLOCATE) && mem_ready;   // Memory word valid now.
    assign busy   = (state != IDLE);

    assign mem_req.addr = {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (start)
                    state_next = COMPARE;
            end
            COMPARE:
            begin
                if (hit)
                    state_next = IDLE;
                else
                    state_next = ALLOCATE;
            end
            ALLOCATE:
            begin
                if (mem_ready)
                    state_next = COMPARE;   // Recheck, hits this time.
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && start)
            req_q <= req;
    end

    // Flush only takes effect between fetches.
    always_ff @(posedge clk)
    begin
        if (rst)
            valid_q <= '0;
        else if (flush && state == IDLE)
            valid_q <= '0;
        else if (refill)
            valid_q[index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (refill)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= mem_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= (state == COMPARE) && hit;
    end

    always_ff @(posedge clk)
    begin
        if (state == COMPARE && hit)
            rsp.data <= data_mem[index];
    end

    // Raised the cycle after a missed compare, held until granted.
    always_ff @(posedge clk)
    begin
        if (rst)
            mem_valid <= 1'b0;
        else if (state == COMPARE && !hit)
            mem_valid <= 1'b1;
        else if (mem_ready)
            mem_valid <= 1'b0;
    end

endmodule

//--- source/refill_collect.sv
module refill_collect #(
    parameter int NUM_BANKS = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [NUM_BANKS-1:0]          bank_mem_valid,
    input  icache_pkg::mem_req_t          bank_mem_req [NUM_BANKS],
    output logic [NUM_BANKS-1:0]          bank_mem_ready,
    input  logic [NUM_BANKS-1:0]          bank_rsp_valid,
    input  icache_pkg::fetch_rsp_t        bank_rsp [NUM_BANKS],
    output logic                          mem_req_valid,
    output logic [icache_pkg::ADDR_W-1:0] mem_req_addr,
    input  logic                          mem_req_ready,
    output logic                          rsp_valid,
    output icache_pkg::fetch_rsp_t        rsp,
    output logic                          rsp_done
);
    import icache_pkg::*;

    localparam int SEL_W = $clog2(NUM_BANKS);

    logic [SEL_W-1:0]  rr_ptr;
    logic [SEL_W-1:0]  grant_q;
    logic              lock;
    logic [SEL_W-1:0]  pick;
    logic [SEL_W-1:0]  cand;
    logic [SEL_W-1:0]  sel;
    logic [WORD_W-1:0] merged;

    // First requester at or after rr_ptr.
    always_comb
    begin
        pick = rr_ptr;
        cand = rr_ptr;
        for (int k = NUM_BANKS - 1; k >= 0; k--)
        begin
            cand = rr_ptr + SEL_W'(k);
            if (bank_mem_valid[cand])
                pick = cand;
        end
    end

    assign sel = lock ? grant_q : pick;   // Grant frozen mid-transfer.

    assign mem_req_valid = bank_mem_valid[sel];
    assign mem_req_addr  = bank_mem_req[sel].addr;

    always_comb
    begin
        bank_mem_ready      = '0;
        bank_mem_ready[sel] = mem_req_valid && mem_req_ready;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lock    <= 1'b0;
            grant_q <= '0;
            rr_ptr  <= '0;
        end
        else if (mem_req_valid)
        begin
            if (mem_req_ready)
            begin
                lock   <= 1'b0;
                rr_ptr <= sel + 1'b1;   // Winner goes to the back.
            end
            else
            begin
                lock    <= 1'b1;
                grant_q <= sel;
            end
        end
    end

    // At most one bank answers in a cycle.
    always_comb
    begin
        merged = '0;
        for (int i = 0; i < NUM_BANKS; i++)
        begin
            if (bank_rsp_valid[i])
                merged = merged | bank_rsp[i].data;
        end
    end

    assign rsp_valid = |bank_rsp_valid;
    assign rsp.data  = merged;
    assign rsp_done  = rsp_valid;

endmodule

//--- source/icache_top.sv
module icache_top #(
    parameter int NUM_BANKS     = 4,
    parameter int SETS_PER_BANK = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          req_valid,
    input  icache_pkg::fetch_req_t        req,
    output logic                          req_ready,
    output logic                          rsp_valid,
    output icache_pkg::fetch_rsp_t        rsp,
    output logic                          mem_req_valid,
    output logic [icache_pkg::ADDR_W-1:0] mem_req_addr,
    input  logic                          mem_req_ready,
    input  logic [icache_pkg::WORD_W-1:0] mem_req_data
);
    import icache_pkg::*;

    logic [NUM_BANKS-1:0] bank_busy;
    logic [NUM_BANKS-1:0] bank_start;
    logic [NUM_BANKS-1:0] bank_rsp_valid;
    logic [NUM_BANKS-1:0] bank_mem_valid;
    logic [NUM_BANKS-1:0] bank_mem_ready;
    fetch_req_t           bank_req;
    fetch_rsp_t           bank_rsp [NUM_BANKS];
    mem_req_t             bank_mem_req [NUM_BANKS];
    logic                 rsp_done;

    fetch_dispatch #(
        .NUM_BANKS (NUM_BANKS)
    ) u_fetch_dispatch (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .bank_busy (bank_busy),
        .rsp_done  (rsp_done),
        .start     (bank_start),
        .bank_req  (bank_req)
    );

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        icache_bank #(
            .NUM_BANKS     (NUM_BANKS),
            .SETS_PER_BANK (SETS_PER_BANK)
        ) u_icache_bank (
            .clk       (clk),
            .rst       (rst),
            .flush     (flush),
            .start     (bank_start[b]),
            .req       (bank_req),
            .busy      (bank_busy[b]),
            .rsp_valid (bank_rsp_valid[b]),
            .rsp       (bank_rsp[b]),
            .mem_valid (bank_mem_valid[b]),
            .mem_req   (bank_mem_req[b]),
            .mem_ready (bank_mem_ready[b]),
            .mem_data  (mem_req_data)   // Shared refill data.
        );
    end

    refill_collect #(
        .NUM_BANKS (NUM_BANKS)
    ) u_refill_collect (
        .clk            (clk),
        .rst            (rst),
        .bank_mem_valid (bank_mem_valid),
        .bank_mem_req   (bank_mem_req),
        .bank_mem_ready (bank_mem_ready),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_ready  (mem_req_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_done       (rsp_done)
    );

endmodule

//--- tests/tb_mem_model.sv
module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h382cd8e6
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req_valid,
    input  logic [15:0] mem_req_addr,
    output logic        mem_req_ready,
    output logic [31:0] mem_req_data,
    output int          req_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] rng;
    logic        pending;
    int          wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word pattern from the full address.
    function automatic logic [31:0] mix_word(input logic [15:0] addr);
        logic [31:0] w;
        w = {18'd0, addr[15:2]};
        return (w * 32'h9e3779b1) ^ {addr, ~addr};
    endfunction

    // Ready comes 0 to 5 cycles after a request is seen.
    always @(negedge clk)
    begin
        if (rst)
        begin
            rng           = SEED;
            pending       = 1'b0;
            wait_cnt      = 0;
            req_count     <= 0;
            mem_req_ready <= 1'b0;
            mem_req_data  <= '0;
        end
        else if (mem_req_ready)
            mem_req_ready <= 1'b0;   // Transfer done at last rising edge.
        else if (mem_req_valid)
        begin
            if (!pending)
            begin
                rng      = lcg_next(rng);
                wait_cnt = (rng >> 16) % 6;
                pending  = 1'b1;
            end
            if (wait_cnt == 0)
            begin
                pending       = 1'b0;
                mem_req_ready <= 1'b1;
                mem_req_data  <= mix_word(mem_req_addr);
                req_count     <= req_count + 1;
            end
            else
                wait_cnt = wait_cnt - 1;
        end
    end

endmodule

//--- tests/tb_icache.sv
module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;
    import icache_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int NUM_BANKS     = 4;
    localparam int SETS          = 16;
    localparam int LINE_W        = $clog2(NUM_BANKS * SETS);
    localparam int TAG_LSB       = OFFSET_W + LINE_W;
    localparam int N_COLD        = 16;
    localparam int N_CONFLICT    = 8;
    localparam int N_RANDOM      = 300;
    localparam int TOTAL_FETCHES = 3 * N_COLD + N_CONFLICT + N_RANDOM;
    localparam int FETCH_BOUND   = 30;   // Cycles, worst miss is about 15.

    logic              clk;
    logic              rst;
    logic              flush;
    logic              req_valid;
    logic              req_ready;
    logic              rsp_valid;
    fetch_req_t        req;
    fetch_rsp_t        rsp;
    logic              mem_req_valid;
    logic              mem_req_ready;
    logic [ADDR_W-1:0] mem_req_addr;
    logic [WORD_W-1:0] mem_req_data;
    int                mem_count;

    // Reference tag store, one entry per bank line.
    logic                     ref_valid [NUM_BANKS*SETS];
    logic [ADDR_W-TAG_LSB-1:0] ref_tag  [NUM_BANKS*SETS];

    logic [WORD_W-1:0] exp_data_q [$];
    logic              exp_hit_q  [$];
    int                accept_q   [$];
    logic [ADDR_W-1:0] fetch_addr = '0;
    int   cycle       = 0;
    int   issued      = 0;
    int   done_count  = 0;
    int   misses      = 0;
    int   checks      = 0;
    int   errors      = 0;
    int   err_start   = 0;
    logic [31:0] rng  = 32'h382cd8e6;

    icache_top #(
        .NUM_BANKS     (NUM_BANKS),
        .SETS_PER_BANK (SETS)
    ) u_icache_top (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data)
    );

    tb_mem_model #(
        .SEED (32'h382cd8e6)
    ) u_mem_model (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_ready (mem_req_ready),
        .mem_req_data  (mem_req_data),
        .req_count     (mem_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected instruction word for an aligned address.
    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [31:0] w;
        w = {18'd0, addr[ADDR_W-1:OFFSET_W]};
        return (w * 32'h9e3779b1) ^ {addr, ~addr};
    endfunction

    function automatic logic predict_hit(input logic [ADDR_W-1:0] addr);
        int line;
        line = addr[OFFSET_W +: LINE_W];
        return ref_valid[line] && (ref_tag[line] == addr[ADDR_W-1:TAG_LSB]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int n);
        $display("%-8s fetches=%0d errors=%0d", name, n, errors - err_start);
        err_start = errors;
    endtask

    task automatic clear_model();
        for (int i = 0; i < NUM_BANKS * SETS; i++)
            ref_valid[i] = 1'b0;
    endtask

    // One fetch, returns after its response was checked.
    task automatic fetch(input logic [ADDR_W-1:0] addr);
        logic hit;
        int   mem_before;
        int   line;
        hit  = predict_hit(addr);
        line = addr[OFFSET_W +: LINE_W];
        @(negedge clk);
        req_valid <= 1'b1;
        req.addr  <= addr;
        do
            @(posedge clk);
        while (!req_ready);
        mem_before = mem_count;
        fetch_addr = addr;
        exp_data_q.push_back(expected_word(addr));
        exp_hit_q.push_back(hit);
        accept_q.push_back(cycle);
        issued++;
        if (!hit)
        begin
            ref_valid[line] = 1'b1;
            ref_tag[line]   = addr[ADDR_W-1:TAG_LSB];
            misses++;
        end
        @(negedge clk);
        req_valid <= 1'b0;
        check_value("req_ready", req_ready, 0);   // Low right after acceptance.
        wait (done_count == issued);
        check_value("mem_req_count", mem_count - mem_before, hit ? 0 : 1);
        @(negedge clk);
        check_value("req_ready", req_ready, 1);   // Back up after the response.
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Refills fetch the word of the outstanding fetch.
    always @(posedge clk)
    begin
        if (!rst && mem_req_valid && mem_req_ready)
            check_value("mem_req_addr", mem_req_addr, fetch_addr);
    end

    // Response checker.
    always @(posedge clk)
    begin
        logic hit_exp;
        int   accepted;
        if (!rst && rsp_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                errors++;
                $display("Response at %0t with no fetch outstanding", $time);
            end
            else
            begin
                check_value("rsp.data", rsp.data, exp_data_q.pop_front());
                hit_exp  = exp_hit_q.pop_front();
                accepted = accept_q.pop_front();
                if (hit_exp)
                    check_value("hit_latency", cycle - accepted, 3);
            end
            done_count++;
        end
    end

    initial
    begin
        #((10 + TOTAL_FETCHES * FETCH_BOUND + 100) * CLK_PERIOD);
        $display("Watchdog expired before all fetches completed");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int m0;
        int c0;
        rst       = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        clear_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("req_ready", req_ready, 1);
        check_value("rsp_valid", rsp_valid, 0);
        check_value("mem_req_valid", mem_req_valid, 0);

        for (int i = 0; i < N_COLD; i++)
            fetch(16'h1000 + 16'(4 * i));
        finish_test("cold", N_COLD);

        for (int i = 0; i < N_COLD; i++)
            fetch(16'h1000 + 16'(4 * i));
        finish_test("hit", N_COLD);

        c0 = mem_count;
        for (int i = 0; i < N_CONFLICT; i++)
            fetch(i[0] ? 16'h5040 : 16'h2040);   // Same bank and index.
        check_value("conflict_mem_reqs", mem_count - c0, N_CONFLICT);
        finish_test("conflict", N_CONFLICT);

        @(negedge clk);
        flush <= 1'b1;
        @(posedge clk);
        check_value("req_ready", req_ready, 0);
        @(negedge clk);
        flush <= 1'b0;
        clear_model();
        c0 = mem_count;
        for (int i = 0; i < N_COLD; i++)
            fetch(16'h1000 + 16'(4 * i));
        check_value("flush_mem_reqs", mem_count - c0, N_COLD);
        finish_test("flush", N_COLD);

        m0 = misses;
        c0 = mem_count;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            rng = lcg_next(rng);
            fetch({6'd0, rng[25:18], 2'b00});   // Four tags per line.
        end
        check_value("random_mem_reqs", mem_count - c0, misses - m0);
        finish_test("random", N_RANDOM);

        $display("fetches=%0d checks=%0d misses=%0d errors=%0d",
                 issued, checks, misses, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
source/icache_pkg.sv
source/fetch_dispatch.sv
source/icache_bank.sv
source/refill_collect.sv
source/icache_top.sv
tests/tb_mem_model.sv
tests/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - source/icache_pkg.sv
      - source/fetch_dispatch.sv
      - source/icache_bank.sv
      - source/refill_collect.sv
      - source/icache_top.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_icache.sv
